/* cache_controller.sv */
module cache_controller
    import cache_pkg::*;
#(
    parameter int WAY_CNT = 4
)
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cpu_req,
    input  cpu_cmd_t                cpu_cmd,
    input  logic                    hit,
    input  logic                    victim_dirty,
    input  logic [TAG_ADDR_LEN-1:0] victim_tag,
    input  word_t                   rd_word,
    input  line_t                   victim_line,
    input  logic                    mem_ack,
    output logic                    cpu_ack,
    output word_t                   rdata,
    output logic                    store_en,
    output logic                    mark_dirty,
    output logic                    fill_en,
    output logic                    mem_req,
    output mem_cmd_t                mem_cmd,
    output line_t                   mem_wline
);

    ctrl_state_e state_q;

    logic     lookup_hit;
    logic     lookup_miss;
    logic     mem_done;
    logic     mem_idle;
    mem_cmd_t wb_cmd;
    mem_cmd_t refill_cmd;

    assign lookup_hit = (state_q == LOOKUP) && cpu_req && hit;
    assign lookup_miss = (state_q == LOOKUP) && cpu_req && !hit;

    // first half of the memory exchange done, or both sides back to idle
    assign mem_done = mem_req && mem_ack;
    assign mem_idle = !mem_req && !mem_ack;

    assign store_en = lookup_hit && cpu_cmd.write;
    assign mark_dirty = lookup_hit && cpu_cmd.write;
    // one cycle only, mem_req drops on the same edge
    assign fill_en = (state_q == REFILL) && mem_done;

    assign wb_cmd.write = 1'b1;
    assign wb_cmd.line_addr.tag = victim_tag;
    assign wb_cmd.line_addr.set = cpu_cmd.addr.fields.set;

    assign refill_cmd.write = 1'b0;
    assign refill_cmd.line_addr.tag = cpu_cmd.addr.fields.tag;
    assign refill_cmd.line_addr.set = cpu_cmd.addr.fields.set;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= LOOKUP;
            cpu_ack <= 1'b0;
            mem_req <= 1'b0;
        end
        else
        begin
            case (state_q)
                LOOKUP:
                begin
                    if (lookup_hit)
                    begin
                        state_q <= RESPOND;
                        cpu_ack <= 1'b1;
                    end
                    else if (lookup_miss)
                    begin
                        state_q <= victim_dirty ? WRITE_BACK : REFILL;
                        mem_req <= 1'b1;
                    end
                end
                WRITE_BACK:
                begin
                    if (mem_done)
                    begin
                        mem_req <= 1'b0;
                    end
                    else if (mem_idle)
                    begin
                        state_q <= REFILL;
                        mem_req <= 1'b1;
                    end
                end
                REFILL:
                begin
                    if (mem_done)
                        mem_req <= 1'b0;
                    else if (mem_idle)
                        state_q <= LOOKUP;
                end
                RESPOND:
                begin
                    if (!cpu_req)
                    begin
                        state_q <= LOOKUP;
                        cpu_ack <= 1'b0;
                    end
                end
                default:
                    state_q <= LOOKUP;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (lookup_hit && !cpu_cmd.write)
            rdata <= rd_word;

        // victim line is captured before the refill overwrites its way
        if (lookup_miss)
        begin
            mem_wline <= victim_line;
            mem_cmd <= victim_dirty ? wb_cmd : refill_cmd;
        end
        else if (state_q == WRITE_BACK && mem_idle)
        begin
            mem_cmd <= refill_cmd;
        end
    end

endmodule

/* cache_data_array.sv */
module cache_data_array
    import cache_pkg::*;
#(
    parameter int WAY_CNT = 4,
    localparam int WAY_W = (WAY_CNT > 1) ? $clog2(WAY_CNT) : 1
)
(
    input  logic             clk,
    input  cpu_cmd_t         cmd,
    input  logic [WAY_W-1:0] hit_way,
    input  logic [WAY_W-1:0] victim_way,
    input  logic             store_en,
    input  logic             fill_en,
    input  line_t            fill_line,
    output word_t            rd_word,
    output line_t            victim_line
);

    line_t data_q [SET_CNT][WAY_CNT];

    logic [SET_ADDR_LEN-1:0] set_idx;
    logic [WORD_OFF_LEN-1:0] word_idx;
    logic [BYTE_OFF_LEN-1:0] byte_off;
    word_t                   merged;

    assign set_idx = cmd.addr.fields.set;
    assign word_idx = cmd.addr.fields.word;
    assign byte_off = cmd.addr.fields.byte_off;

    assign rd_word = data_q[set_idx][hit_way][word_idx];
    assign victim_line = data_q[set_idx][victim_way];

    // byte lanes are big-endian, offset 0 is the top byte
    always_comb
    begin
        merged = rd_word;
        case (cmd.size)
            ST_BYTE:
                merged[8 * (3 - int'(byte_off)) +: 8] = cmd.wdata[7:0];
            ST_HALF:
            begin
                if (byte_off[1])
                    merged[15:0] = cmd.wdata[15:0];
                else
                    merged[31:16] = cmd.wdata[15:0];
            end
            default:
                merged = cmd.wdata;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
            data_q[set_idx][victim_way] <= fill_line;
        else if (store_en)
            data_q[set_idx][hit_way][word_idx] <= merged;
    end

endmodule

/* cache_pkg.sv */
package cache_pkg;

    // address layout, low to high: byte offset, word in line, set, tag
    localparam int BYTE_OFF_LEN = 2;
    localparam int WORD_OFF_LEN = 3;
    localparam int SET_ADDR_LEN = 3;
    localparam int TAG_ADDR_LEN = 10;
    localparam int UNUSED_LEN = 32 - TAG_ADDR_LEN - SET_ADDR_LEN - WORD_OFF_LEN - BYTE_OFF_LEN;

    localparam int LINE_WORDS = 1 << WORD_OFF_LEN;
    localparam int SET_CNT = 1 << SET_ADDR_LEN;

    typedef logic [31:0] word_t;

    // word 0 of the line sits in the most significant slot
    typedef logic [0:LINE_WORDS-1][31:0] line_t;

    // line number as memory sees it
    typedef struct packed {
        logic [TAG_ADDR_LEN-1:0] tag;
        logic [SET_ADDR_LEN-1:0] set;
    } line_addr_t;

    typedef struct packed {
        logic [UNUSED_LEN-1:0]   unused;
        logic [TAG_ADDR_LEN-1:0] tag;
        logic [SET_ADDR_LEN-1:0] set;
        logic [WORD_OFF_LEN-1:0] word;
        logic [BYTE_OFF_LEN-1:0] byte_off;
    } addr_fields_t;

    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t fields;
    } cache_addr_u;

    typedef enum logic [1:0] {
        ST_BYTE,
        ST_HALF,
        ST_WORD
    } store_size_e;

    typedef struct packed {
        logic        write;
        store_size_e size;
        cache_addr_u addr;
        word_t       wdata;
    } cpu_cmd_t;

    typedef struct packed {
        logic       write;
        line_addr_t line_addr;
    } mem_cmd_t;

    typedef enum logic [1:0] {
        LOOKUP,
        WRITE_BACK,
        REFILL,
        RESPOND
    } ctrl_state_e;

endpackage

/* cache_tag_array.sv */
module cache_tag_array
    import cache_pkg::*;
#(
    parameter int WAY_CNT = 4,
    localparam int WAY_W = (WAY_CNT > 1) ? $clog2(WAY_CNT) : 1
)
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  cache_addr_u             addr,
    input  logic                    mark_dirty,
    input  logic                    fill_en,
    output logic                    hit,
    output logic [WAY_W-1:0]        hit_way,
    output logic [WAY_W-1:0]        victim_way,
    output logic                    victim_dirty,
    output logic [TAG_ADDR_LEN-1:0] victim_tag
);

    logic [TAG_ADDR_LEN-1:0] tag_q [SET_CNT][WAY_CNT];
    logic [WAY_CNT-1:0]      valid_q [SET_CNT];
    logic [WAY_CNT-1:0]      dirty_q [SET_CNT];
    // next way to replace in each set, filled in round-robin order
    logic [WAY_W-1:0]        fifo_ptr_q [SET_CNT];

    logic [SET_ADDR_LEN-1:0] set_idx;
    logic [TAG_ADDR_LEN-1:0] req_tag;
    logic [WAY_W-1:0]        next_ptr;

    assign set_idx = addr.fields.set;
    assign req_tag = addr.fields.tag;

    // first valid way with a matching tag wins
    always_comb
    begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAY_CNT; w++)
        begin
            if (!hit && valid_q[set_idx][w] && tag_q[set_idx][w] == req_tag)
            begin
                hit = 1'b1;
                hit_way = WAY_W'(w);
            end
        end
    end

    assign victim_way = fifo_ptr_q[set_idx];
    assign victim_tag = tag_q[set_idx][victim_way];
    assign victim_dirty = valid_q[set_idx][victim_way] && dirty_q[set_idx][victim_way];

    // wrap by compare so a single way keeps the pointer at 0
    assign next_ptr = (victim_way == WAY_W'(WAY_CNT - 1)) ? '0 : victim_way + 1'b1;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int s = 0; s < SET_CNT; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                fifo_ptr_q[s] <= '0;
            end
        end
        else if (fill_en)
        begin
            valid_q[set_idx][victim_way] <= 1'b1;
            dirty_q[set_idx][victim_way] <= 1'b0;
            fifo_ptr_q[set_idx] <= next_ptr;
        end
        else if (mark_dirty)
        begin
            dirty_q[set_idx][hit_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
            tag_q[set_idx][victim_way] <= req_tag;
    end

endmodule

/* cache_tests.txt */
// columns: op (0 read, 1 write) size (0 byte, 1 half, 2 word) address wdata rdata refills
// memory word = C0DE in the upper half, low 16 bits of line*16+word in the lower half
0 2 00000000 00000000 C0DE0000 1
0 2 0000001C 00000000 C0DE0007 0
0 2 00000000 00000000 C0DE0000 0
0 2 0000A5C8 00000000 C0DE52E2 1
0 2 0003FFEC 00000000 C0DEFFF3 1
1 2 00000004 11223344 00000000 0
0 2 00000004 00000000 11223344 0
1 0 00000005 000000AA 00000000 0
1 0 00000007 0000005B 00000000 0
0 2 00000004 00000000 11AA335B 0
1 1 00000006 0000BEEF 00000000 0
0 2 00000004 00000000 11AABEEF 0
1 1 00000004 00001234 00000000 0
0 2 00000004 00000000 1234BEEF 0
1 0 00000008 00000077 00000000 0
1 0 0000000A 00000066 00000000 0
0 2 00000008 00000000 77DE6602 0
1 2 00000120 DEADBEEF 00000000 1
0 2 00000220 00000000 C0DE0110 1
0 2 00000320 00000000 C0DE0190 1
0 2 00000420 00000000 C0DE0210 1
0 2 00000520 00000000 C0DE0290 1
0 2 00000220 00000000 C0DE0110 0
0 2 00000120 00000000 DEADBEEF 1
0 2 00000124 00000000 C0DE0091 0

/* data_cache.sv */
module data_cache
    import cache_pkg::*;
#(
    parameter int WAY_CNT = 4,
    localparam int WAY_W = (WAY_CNT > 1) ? $clog2(WAY_CNT) : 1
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cpu_req,
    input  cpu_cmd_t cpu_cmd,
    output logic     cpu_ack,
    output word_t    rdata,
    output logic     mem_req,
    output mem_cmd_t mem_cmd,
    output line_t    mem_wline,
    input  logic     mem_ack,
    input  line_t    mem_rline
);

    logic                    hit;
    logic [WAY_W-1:0]        hit_way;
    logic [WAY_W-1:0]        victim_way;
    logic                    victim_dirty;
    logic [TAG_ADDR_LEN-1:0] victim_tag;
    logic                    store_en;
    logic                    mark_dirty;
    logic                    fill_en;
    word_t                   rd_word;
    line_t                   victim_line;

    cache_tag_array #(
        .WAY_CNT(WAY_CNT)
    ) i_tag_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (cpu_cmd.addr),
        .mark_dirty  (mark_dirty),
        .fill_en     (fill_en),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag)
    );

    // refill data comes straight from the memory port
    cache_data_array #(
        .WAY_CNT(WAY_CNT)
    ) i_data_array (
        .clk        (clk),
        .cmd        (cpu_cmd),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .store_en   (store_en),
        .fill_en    (fill_en),
        .fill_line  (mem_rline),
        .rd_word    (rd_word),
        .victim_line(victim_line)
    );

    cache_controller #(
        .WAY_CNT(WAY_CNT)
    ) i_controller (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_req     (cpu_req),
        .cpu_cmd     (cpu_cmd),
        .hit         (hit),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag),
        .rd_word     (rd_word),
        .victim_line (victim_line),
        .mem_ack     (mem_ack),
        .cpu_ack     (cpu_ack),
        .rdata       (rdata),
        .store_en    (store_en),
        .mark_dirty  (mark_dirty),
        .fill_en     (fill_en),
        .mem_req     (mem_req),
        .mem_cmd     (mem_cmd),
        .mem_wline   (mem_wline)
    );

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_data_cache -o sim_data_cache
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_data_cache)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1

/* tb_data_cache.sv */
module tb_data_cache
    import cache_pkg::*;
();

    localparam int WAY_CNT = 4;
    localparam int MAX_TESTS = 64;
    // op, size, address, write data, expected data, expected refills
    localparam int FIELDS = 6;

    logic     clk;
    logic     rst_n;
    logic     cpu_req;
    cpu_cmd_t cpu_cmd;
    logic     cpu_ack;
    word_t    rdata;
    logic     mem_req;
    mem_cmd_t mem_cmd;
    line_t    mem_wline;
    logic     mem_ack;
    line_t    mem_rline;
    int       read_count;

    logic [31:0] test_mem [FIELDS * MAX_TESTS];
    int          test_cnt;
    int          err_cnt;
    int          cycle_cnt;
    int          cycle_limit;

    data_cache #(
        .WAY_CNT(WAY_CNT)
    ) i_data_cache (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_req  (cpu_req),
        .cpu_cmd  (cpu_cmd),
        .cpu_ack  (cpu_ack),
        .rdata    (rdata),
        .mem_req  (mem_req),
        .mem_cmd  (mem_cmd),
        .mem_wline(mem_wline),
        .mem_ack  (mem_ack),
        .mem_rline(mem_rline)
    );

    tb_main_memory i_main_memory (
        .clk       (clk),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .mem_wline (mem_wline),
        .mem_ack   (mem_ack),
        .mem_rline (mem_rline),
        .read_count(read_count)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("Error: simulation timed out after %0d cycles", cycle_cnt);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_word(input word_t got, input word_t exp, input string msg);
        if (got !== exp)
        begin
            err_cnt++;
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string msg);
        if (got != exp)
        begin
            err_cnt++;
            $display("Mismatch at %0t: %s, got %0d, expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp)
        begin
            err_cnt++;
            $display("Mismatch at %0t: %s, got %b, expected %b", $time, msg, got, exp);
        end
    endtask

    // one full four-phase exchange on the CPU port, then compare
    task automatic run_request(input int idx);
        int       base;
        int       refills_before;
        cpu_cmd_t cmd;
        base = FIELDS * idx;
        cmd.write = test_mem[base][0];
        cmd.size = store_size_e'(test_mem[base + 1][1:0]);
        cmd.addr.raw = test_mem[base + 2];
        cmd.wdata = test_mem[base + 3];
        @(negedge clk);
        refills_before = read_count;
        cpu_cmd = cmd;
        cpu_req = 1'b1;
        @(negedge clk);
        while (!cpu_ack)
            @(negedge clk);
        if (!cmd.write)
            check_word(rdata, test_mem[base + 4],
                $sformatf("test %0d read at %h", idx, cmd.addr.raw));
        check_count(read_count - refills_before, int'(test_mem[base + 5]),
            $sformatf("test %0d refills at %h", idx, cmd.addr.raw));
        cpu_req = 1'b0;
        @(negedge clk);
        while (cpu_ack)
            @(negedge clk);
    endtask

    initial
    begin
        clk = 1'b0;
        rst_n = 1'b0;
        cpu_req = 1'b0;
        cpu_cmd = '0;
        err_cnt = 0;
        cycle_cnt = 0;
        test_cnt = 0;
        cycle_limit = 100;
        for (int i = 0; i < FIELDS * MAX_TESTS; i++)
            test_mem[i] = '1;
        $readmemh("cache_tests.txt", test_mem);
        // an all-ones op field marks the end of the loaded tests
        while (test_cnt < MAX_TESTS && test_mem[FIELDS * test_cnt] !== '1)
            test_cnt++;
        cycle_limit = 60 * test_cnt + 100;
        if (test_cnt == 0)
        begin
            err_cnt++;
            $display("Error: no tests were read from cache_tests.txt");
        end

        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_flag(cpu_ack, 1'b0, "cpu_ack after reset");
        check_flag(mem_req, 1'b0, "mem_req after reset");

        for (int i = 0; i < test_cnt; i++)
            run_request(i);

        $display("tests run: %0d, errors: %0d", test_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* tb_main_memory.sv */
module tb_main_memory
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     mem_req,
    input  mem_cmd_t mem_cmd,
    input  line_t    mem_wline,
    output logic     mem_ack,
    output line_t    mem_rline,
    output int       read_count
);

    localparam int LINE_CNT = 1 << (TAG_ADDR_LEN + SET_ADDR_LEN);

    line_t       mem [LINE_CNT];
    logic [31:0] rng_state;
    int          delay;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // each word holds its own line number and word index
    initial
    begin
        mem_ack = 1'b0;
        mem_rline = '0;
        read_count = 0;
        rng_state = 32'h9bd1;
        for (int l = 0; l < LINE_CNT; l++)
        begin
            for (int w = 0; w < LINE_WORDS; w++)
                mem[l][w] = {16'hC0DE, 16'(l * 16 + w)};
        end
    end

    // answers one four-phase exchange at a time, outputs change on falling edges
    always
    begin
        @(negedge clk);
        if (mem_req && !mem_ack)
        begin
            rng_state = xorshift(rng_state);
            delay = int'(rng_state[1:0]) + 1;
            repeat (delay) @(negedge clk);
            if (mem_cmd.write)
            begin
                mem[mem_cmd.line_addr] = mem_wline;
            end
            else
            begin
                mem_rline = mem[mem_cmd.line_addr];
                read_count = read_count + 1;
            end
            mem_ack = 1'b1;
            @(negedge clk);
            while (mem_req)
                @(negedge clk);
            mem_ack = 1'b0;
        end
    end

endmodule

/* verilog.f */
cache_pkg.sv
cache_tag_array.sv
cache_data_array.sv
cache_controller.sv
data_cache.sv
tb_main_memory.sv
tb_data_cache.sv
